// File: test/stepper_trace.txt
# W addr data (hex) | P dir count | C name phase (b2 b1 a2 a1, binary)
# D name vref_a_high vref_b_high (cycles per 256, decimal)
C reset_phase 0000
D reset_vref 0 0
P 1 3
C pulse_disabled 0000
W 0 8000
C enable_home 1010
P 1 1
C full_fwd_1 0101
P 1 1
C full_fwd_2 1010
P 1 3
C full_fwd_3 0101
P 0 1
C full_back_1 1010
P 0 1
C full_back_2 0101
W 0 A000
P 1 1
C half_fwd_1 1001
P 1 1
C half_fwd_2 1010
P 1 1
C half_fwd_3 0110
P 0 2
C half_back_1 1001
W 0 C000
P 1 1
C quarter_fwd_1 1000
P 1 1
C quarter_wrap 1010
P 1 3
C quarter_fwd_2 0100
P 0 2
C quarter_back_1 0010
W 0 E000
P 1 1
C code3_fwd_1 0110
P 1 4
C code3_fwd_2 1001
P 1 3
C before_home 0010
W 0 4000
C disabled 0000
W 0 C000
C home_entry0 1010
P 1 1
C after_home 0010
W 1 00C8
D duty_0_200 0 200
W 1 40FF
D duty_64_255 64 255
W 1 C840
D duty_200_64 200 64
W 1 FF00
D duty_255_0 255 0

// File: stepper_drive.f
common/stepper_pkg.sv
hw/cfg_regs.sv
hbridge/phase_sequencer.sv
hbridge/vref_pwm.sv
hw/stepper_top.sv
test/tb_stepper.sv

// File: Bender.yml
package:
  name: stepper_drive

sources:
  # Shared package first
  - files:
      - common/stepper_pkg.sv
  # Design
  - files:
      - hw/cfg_regs.sv
      - hbridge/phase_sequencer.sv
      - hbridge/vref_pwm.sv
      - hw/stepper_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_stepper.sv

// File: test/tb_stepper.sv
`timescale 1ns/1ps

module tb_stepper;

  import stepper_pkg::*;

  localparam int PERIOD_CYC = 1 << CURRENT_W;  // PWM period in clock cycles

  logic      step;
  logic      arst_n;
  logic      cfg_we;
  logic      cfg_addr;
  cfg_word_u cfg_wdata;
  logic      pulse;
  logic      dir;
  phase_t    phase;
  logic      vref_a;
  logic      vref_b;

  int test_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int rec_total  = 0;  // Trace records, sizes the watchdog

  stepper_top DUT (
    .step      (step),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .pulse     (pulse),
    .dir       (dir),
    .phase     (phase),
    .vref_a    (vref_a),
    .vref_b    (vref_b)
  );

  // 20 ns clock
  initial begin
    step = 1'b0;
    forever #10 step = ~step;
  end

  // Every wait ends 2 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge step);
    #2;
  endtask

  task automatic report_test(input string name, input bit ok);
    test_count++;
    if (ok) begin
      pass_count++;
      $display("test %s ok", name);
    end else begin
      fail_count++;
      $display("test %s failed", name);
    end
  endtask

  // Single-cycle strobe, then one quiet cycle
  task automatic write_cfg(input logic addr, input logic [CFG_W-1:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    idle_cycles(1);
    cfg_we    = 1'b0;
    idle_cycles(1);
  endtask

  // One pulse every 4 cycles
  // Quiet gap comes first so the last strobe ends the task
  task automatic send_pulses(input logic d, input int count);
    for (int i = 0; i < count; i++) begin
      idle_cycles(3);
      dir   = d;
      pulse = 1'b1;
      idle_cycles(1);
      pulse = 1'b0;
    end
  endtask

  task automatic compare_phase(input string name, input logic [3:0] expected);
    bit ok;
    ok = 1'b1;
    idle_cycles(1);  // Second cycle after the pulse was driven
    assert (phase === expected) else begin
      $display("mismatch %s expected %b actual %b", name, expected, phase);
      ok = 1'b0;
    end
    report_test(name, ok);
  endtask

  // Count high cycles over one period, after the new duty is latched
  task automatic measure_duty(input string name, input int exp_a, input int exp_b);
    bit ok;
    int cnt_a;
    int cnt_b;
    ok    = 1'b1;
    cnt_a = 0;
    cnt_b = 0;
    idle_cycles(PERIOD_CYC + 4);  // At least one wrap passed
    for (int i = 0; i < PERIOD_CYC; i++) begin
      if (vref_a === 1'b1) cnt_a++;
      if (vref_b === 1'b1) cnt_b++;
      idle_cycles(1);
    end
    assert (cnt_a == exp_a) else begin
      $display("mismatch %s vref_a expected %0d actual %0d", name, exp_a, cnt_a);
      ok = 1'b0;
    end
    assert (cnt_b == exp_b) else begin
      $display("mismatch %s vref_b expected %0d actual %0d", name, exp_b, cnt_b);
      ok = 1'b0;
    end
    report_test(name, ok);
  endtask

  // Limit scales with the trace length
  initial begin
    wait (rec_total > 0);
    #(rec_total * 600 * 20);
    $display("run timed out before the trace finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int                  fd;
    int                  code;
    bit                  done;
    string               kind;
    string               name;
    logic [8*128-1:0]    rest;  // Remainder of a skipped line
    logic                addr;
    logic [CFG_W-1:0]    data;
    int                  d;
    int                  count;
    logic [3:0]          exp_phase;
    int                  exp_a;
    int                  exp_b;

    arst_n    = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    pulse     = 1'b0;
    dir       = 1'b1;

    // First pass only counts records
    fd = $fopen("test/stepper_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open test/stepper_trace.txt");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %s", kind);
        if (code != 1) begin
          done = 1'b1;
        end else begin
          if (kind != "#") rec_total++;
          code = $fgets(rest, fd);
        end
      end
      $fclose(fd);

      repeat (5) @(posedge step);  // Reset held 5 cycles
      #2;
      arst_n = 1'b1;

      fd   = $fopen("test/stepper_trace.txt", "r");
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %s", kind);
        if (code != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          code = $fgets(rest, fd);  // Column notes
        end else if (kind == "W") begin
          code = $fscanf(fd, " %h %h", addr, data);
          write_cfg(addr, data);
        end else if (kind == "P") begin
          code = $fscanf(fd, " %d %d", d, count);
          send_pulses(d[0], count);
        end else if (kind == "C") begin
          code = $fscanf(fd, " %s %b", name, exp_phase);
          compare_phase(name, exp_phase);
        end else if (kind == "D") begin
          code = $fscanf(fd, " %s %d %d", name, exp_a, exp_b);
          measure_duty(name, exp_a, exp_b);
        end else begin
          $display("unknown record kind %s in trace file", kind);
          fail_count++;
          code = $fgets(rest, fd);
        end
      end
      $fclose(fd);

      $display("tests run %0d passed %0d failed %0d", test_count, pass_count, fail_count);
      if (fail_count == 0 && test_count > 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

// File: hw/stepper_top.sv
`timescale 1ns/1ps

module stepper_top (
  input  logic                   step,
  input  logic                   arst_n,
  // Configuration write port
  input  logic                   cfg_we,
  input  logic                   cfg_addr,
  input  stepper_pkg::cfg_word_u cfg_wdata,
  // Motion
  input  logic                   pulse,
  input  logic                   dir,      // Sampled with pulse
  // Bridge drive
  output stepper_pkg::phase_t    phase,
  output logic                   vref_a,   // Winding current, bridge A
  output logic                   vref_b    // Winding current, bridge B
);

  import stepper_pkg::*;

  cfg_t cfg;   // Live configuration
  logic home;  // Enable 0 to 1 strobe

  // Register block, one write per cycle
  cfg_regs u_cfg_regs (
    .step      (step),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg),
    .home      (home)
  );

  // Pulse to phase, two cycles
  phase_sequencer u_phase_sequencer (
    .step   (step),
    .arst_n (arst_n),
    .pulse  (pulse),
    .dir    (dir),
    .home   (home),
    .cfg    (cfg),
    .phase  (phase)
  );

  // Reference for bridge A
  vref_pwm pwm_a (
    .step   (step),
    .arst_n (arst_n),
    .duty   (cfg.current_a),
    .vref   (vref_a)
  );

  // Reference for bridge B
  // Counters run in lockstep with pwm_a, both leave reset together
  vref_pwm pwm_b (
    .step   (step),
    .arst_n (arst_n),
    .duty   (cfg.current_b),
    .vref   (vref_b)
  );

endmodule

// File: hbridge/vref_pwm.sv
`timescale 1ns/1ps

module vref_pwm (
  input  logic                              step,
  input  logic                              arst_n,
  input  logic [stepper_pkg::CURRENT_W-1:0] duty,  // High cycles per period
  output logic                              vref
);

  import stepper_pkg::*;

  logic [CURRENT_W-1:0] cnt;     // Free-running, period 256
  logic [CURRENT_W-1:0] duty_q;  // Duty held for a whole period
  logic                 wrap;

  assign wrap = (cnt == '1);  // Last cycle of the period

  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;  // Rolls over on its own
    end
  end

  // New duty only at the wrap, no glitch mid-period
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      duty_q <= '0;  // Output low out of reset
    end else if (wrap) begin
      duty_q <= duty;
    end
  end

  // High while counter is below duty
  // 255 gives 255 of 256, never fully on
  assign vref = (cnt < duty_q);

  // Zero duty at the wrap keeps the reference low for a full period
  a_zero_duty : assert property (
    @(posedge step) disable iff (!arst_n)
    (wrap && duty == '0) |=> (!vref)[*(1<<CURRENT_W)]
  );

endmodule

// File: hbridge/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
  input  logic                step,
  input  logic                arst_n,
  input  logic                pulse,   // Motor step strobe
  input  logic                dir,     // 1 forward, 0 backward
  input  logic                home,    // Return index to entry 0
  input  stepper_pkg::cfg_t   cfg,
  output stepper_pkg::phase_t phase
);

  import stepper_pkg::*;

  logic [PHASE_W-1:0] idx;       // Position in PHASE_TABLE
  logic [PHASE_W-1:0] step_mag;  // Table stride per pulse
  logic [PHASE_W-1:0] step_inc;  // Signed stride, two's complement

  // Full step jumps 4 entries, half 2, quarter 1
  assign step_mag = PHASE_W'(4) >> cfg.microstep;

  // Backward walk by negation
  // Wraps modulo 8 through the index width
  always_comb begin
    if (dir) begin
      step_inc = step_mag;
    end else begin
      step_inc = -step_mag;
    end
  end

  // Index counter
  // Home wins over a pulse in the same cycle
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      idx <= '0;
    end else if (home) begin
      idx <= '0;  // Entry 0, both coils on
    end else if (pulse) begin
      idx <= idx + step_inc;
    end
  end

  // Registered lookup, one cycle behind the index
  // Disable forces every bridge leg off
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      phase <= '0;
    end else if (!cfg.enable) begin
      phase <= '0;
    end else begin
      phase <= phase_t'(PHASE_TABLE[idx]);
    end
  end

  // Zero stride would mean a pulse is silently dropped
  // Depends on the clamp in the register block
  a_inc_nonzero : assert property (
    @(posedge step) disable iff (!arst_n)
    pulse |-> (step_mag != '0)
  );

  // Bridges released one cycle after enable drops
  a_disable_off : assert property (
    @(posedge step) disable iff (!arst_n)
    !cfg.enable |=> (phase == '0)
  );

endmodule

// File: hw/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
  input  logic                  step,
  input  logic                  arst_n,
  input  logic                  cfg_we,     // Single-cycle write strobe
  input  logic                  cfg_addr,   // 0 control, 1 currents
  input  stepper_pkg::cfg_word_u cfg_wdata,
  output stepper_pkg::cfg_t     cfg,
  output logic                  home        // One cycle, enable rising
);

  import stepper_pkg::*;

  logic               wr_ctrl;    // Write to address 0
  logic               wr_cur;     // Write to address 1
  logic [MSTEP_W-1:0] mstep_sat;  // Microstep code after clamp
  logic               home_d;

  assign wr_ctrl = cfg_we && !cfg_addr;
  assign wr_cur  = cfg_we &&  cfg_addr;

  // Code 3 would give a zero increment and stall the motor
  // Clamp it to quarter step
  always_comb begin
    if (cfg_wdata.ctrl.microstep == '1) begin
      mstep_sat = MSTEP_W'(2);
    end else begin
      mstep_sat = cfg_wdata.ctrl.microstep;
    end
  end

  // Homing only on a 0 to 1 edge of enable
  // Rewriting enable 1 while already enabled does not home
  assign home_d = wr_ctrl && cfg_wdata.ctrl.enable && !cfg.enable;

  // Control fields
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      cfg.enable    <= 1'b0;
      cfg.microstep <= '0;  // Full step
    end else if (wr_ctrl) begin
      cfg.enable    <= cfg_wdata.ctrl.enable;
      cfg.microstep <= mstep_sat;
    end
  end

  // Current fields
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      cfg.current_a <= '0;  // Both bridges idle after reset
      cfg.current_b <= '0;
    end else if (wr_cur) begin
      cfg.current_a <= cfg_wdata.cur.current_a;
      cfg.current_b <= cfg_wdata.cur.current_b;
    end
  end

  // Homing strobe
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      home <= 1'b0;
    end else begin
      home <= home_d;  // High for the cycle after the write
    end
  end

  // A write needs a known address, else one view is lost
  a_addr_known : assert property (
    @(posedge step) disable iff (!arst_n)
    cfg_we |-> !$isunknown(cfg_addr)
  );

endmodule

// File: common/stepper_pkg.sv
package stepper_pkg;

  // Widths
  localparam int PHASE_W   = 3;   // Eight-entry phase table
  localparam int CURRENT_W = 8;   // Current setting, also PWM counter width
  localparam int MSTEP_W   = 2;   // Microstep code
  localparam int CFG_W     = 16;  // One configuration write word

  // Coil patterns in index order
  // Bit order b2 b1 a2 a1, MSB first
  // Even entries are full steps, odd entries the half steps between
  localparam logic [3:0] PHASE_TABLE [0:(1<<PHASE_W)-1] = '{
    4'b1010,  // 0, both coils on
    4'b0010,  // 1, coil A only
    4'b0110,
    4'b0100,  // 3, coil B only
    4'b0101,  // 4, both reversed
    4'b0001,
    4'b1001,
    4'b1000   // 7, wraps back to 0
  };

  // Bridge drive bits, packed to match PHASE_TABLE bit order
  typedef struct packed {
    logic b2;
    logic b1;
    logic a2;
    logic a1;
  } phase_t;

  // Live configuration, fanned out from the register block
  typedef struct packed {
    logic                 enable;     // Gates all four bridge outputs
    logic [MSTEP_W-1:0]   microstep;  // 0 full, 1 half, 2 quarter
    logic [CURRENT_W-1:0] current_a;  // PWM duty, bridge A
    logic [CURRENT_W-1:0] current_b;  // PWM duty, bridge B
  } cfg_t;

  // Address 0 view
  typedef struct packed {
    logic                     enable;
    logic [MSTEP_W-1:0]       microstep;
    logic [CFG_W-MSTEP_W-2:0] rsvd;  // Ignored on write
  } cfg_ctrl_t;

  // Address 1 view
  typedef struct packed {
    logic [CURRENT_W-1:0] current_a;  // Upper byte
    logic [CURRENT_W-1:0] current_b;  // Lower byte
  } cfg_cur_t;

  // Configuration write word, decoded by address
  typedef union packed {
    cfg_ctrl_t ctrl;
    cfg_cur_t  cur;
  } cfg_word_u;

endpackage
